//--- verilog/cpuPkg.sv
package cpuPkg;

	localparam int dataWidth = 16;
	localparam int regCount = 16;
	localparam int regIdxWidth = $clog2(regCount);
	localparam int memDepth = 256;
	localparam int memIdxWidth = $clog2(memDepth);

	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_AND = 4'h2,
		OP_OR  = 4'h3,
		OP_XOR = 4'h4,
		OP_SHL = 4'h5,
		OP_SHR = 4'h6,
		OP_MOV = 4'h7,
		OP_LDI = 4'h8,
		OP_LD  = 4'h9,
		OP_ST  = 4'hA,
		OP_STA = 4'hB,
		OP_JMP = 4'hC,
		OP_JZ  = 4'hD,
		OP_JC  = 4'hE,
		OP_JR  = 4'hF
	} opcodeT;

	// Register form, low nibble unused
	typedef struct packed {
		opcodeT opcode;
		logic [regIdxWidth-1:0] dst;
		logic [regIdxWidth-1:0] src;
		logic [3:0] unused;
	} regFormT;

	typedef struct packed {
		opcodeT opcode;
		logic [regIdxWidth-1:0] dst;
		logic [7:0] imm8;
	} immFormT;

	typedef union packed {
		regFormT r;
		immFormT i;
	} instrT;

	typedef enum logic [1:0] {
		PC_INC = 2'd0,
		PC_ABS = 2'd1,
		PC_REG = 2'd2
	} nextPcSelT;

	typedef enum logic [1:0] {
		FETCH = 2'd0,
		EXEC  = 2'd1,
		WBACK = 2'd2
	} stateT;

endpackage

//--- verilog/memBusIf.sv
interface memBusIf;
	import cpuPkg::*;

	logic [dataWidth-1:0] addr;
	logic we;
	logic [dataWidth-1:0] wdata;
	// Combinational read of the addressed word
	logic [dataWidth-1:0] rdata;

	modport master(output addr, we, wdata, input rdata);
	modport slave(input addr, we, wdata, output rdata);

endinterface

//--- verilog/decodeIf.sv
interface decodeIf;
	import cpuPkg::*;

	opcodeT opcode;
	logic [regIdxWidth-1:0] regDst;
	logic [regIdxWidth-1:0] regSrc;
	logic regFileWe;
	logic memWe;
	logic immMode;
	logic indMode;
	logic addrSelDst;
	logic addrSelSrc;
	nextPcSelT nextPcSel;
	logic [dataWidth-1:0] instrData;

	modport source(output opcode, regDst, regSrc, regFileWe, memWe, immMode, indMode,
		addrSelDst, addrSelSrc, nextPcSel, instrData);
	modport sink(input opcode, regDst, regSrc, regFileWe, memWe, immMode, indMode,
		addrSelDst, addrSelSrc, nextPcSel, instrData);

endinterface

//--- verilog/regFile.sv
module regFile(
	input logic clk,
	input logic rst,
	input logic we,
	input logic [cpuPkg::regIdxWidth-1:0] regDst,
	input logic [cpuPkg::regIdxWidth-1:0] regSrc,
	input logic [cpuPkg::dataWidth-1:0] wrData,
	output logic [cpuPkg::dataWidth-1:0] dstData,
	output logic [cpuPkg::dataWidth-1:0] srcData
);
	import cpuPkg::*;

	logic [dataWidth-1:0] regs [regCount];

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[regDst] <= wrData;
		end
	end

	assign dstData = regs[regDst];
	assign srcData = regs[regSrc];

endmodule

//--- verilog/alu.sv
module alu(
	input logic clk,
	input logic rst,
	input logic update,
	input cpuPkg::opcodeT op,
	input logic [cpuPkg::dataWidth-1:0] in1,
	input logic [cpuPkg::dataWidth-1:0] in2,
	output logic [cpuPkg::dataWidth-1:0] result,
	output logic cFlag,
	output logic zFlag
);
	import cpuPkg::*;

	// Top bit holds carry, borrow or the shifted-out bit
	logic [dataWidth:0] wide;

	always_comb begin
		case (op)
			OP_ADD: wide = {1'b0, in1} + {1'b0, in2};
			OP_SUB: wide = {1'b0, in1} - {1'b0, in2};
			OP_AND: wide = {1'b0, in1 & in2};
			OP_OR:  wide = {1'b0, in1 | in2};
			OP_XOR: wide = {1'b0, in1 ^ in2};
			OP_SHL: wide = {in1, 1'b0};
			OP_SHR: wide = {in1[0], 1'b0, in1[dataWidth-1:1]};
			OP_MOV: wide = {1'b0, in2};
			default: wide = {1'b0, in1};
		endcase
	end

	assign result = wide[dataWidth-1:0];

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			cFlag <= 1'b0;
			zFlag <= 1'b0;
		end else if (update) begin
			cFlag <= wide[dataWidth];
			zFlag <= (wide[dataWidth-1:0] == '0);
		end
	end

	flagsHold: assert property (@(posedge clk) disable iff (rst)
		!update |=> $stable({cFlag, zFlag}));

endmodule

//--- verilog/decoder.sv
module decoder(
	input cpuPkg::instrT instr,
	input logic cFlag,
	input logic zFlag,
	decodeIf.source ctl
);
	import cpuPkg::*;

	opcodeT op;
	logic immForm;

	assign op = instr.r.opcode;
	assign immForm = op inside {OP_LDI, OP_STA, OP_JMP, OP_JZ, OP_JC};

	assign ctl.opcode = op;
	assign ctl.regDst = instr.r.dst;
	// STA keeps its source register in the dst field
	assign ctl.regSrc = (op == OP_STA) ? instr.i.dst : instr.r.src;
	assign ctl.instrData = immForm ? {{(dataWidth - 8){1'b0}}, instr.i.imm8} : '0;

	always_comb begin
		ctl.regFileWe = 1'b0;
		ctl.memWe = 1'b0;
		ctl.immMode = 1'b0;
		ctl.indMode = 1'b0;
		ctl.addrSelDst = 1'b0;
		ctl.addrSelSrc = 1'b0;
		ctl.nextPcSel = PC_INC;
		case (op)
			OP_LDI: begin
				ctl.regFileWe = 1'b1;
				ctl.immMode = 1'b1;
			end
			OP_LD: begin
				ctl.regFileWe = 1'b1;
				ctl.indMode = 1'b1;
				ctl.addrSelSrc = 1'b1;
			end
			OP_ST: begin
				ctl.memWe = 1'b1;
				ctl.addrSelDst = 1'b1;
			end
			OP_STA: ctl.memWe = 1'b1;
			OP_JMP: ctl.nextPcSel = PC_ABS;
			OP_JZ: ctl.nextPcSel = zFlag ? PC_ABS : PC_INC;
			OP_JC: ctl.nextPcSel = cFlag ? PC_ABS : PC_INC;
			OP_JR: ctl.nextPcSel = PC_REG;
			// ALU group
			default: ctl.regFileWe = 1'b1;
		endcase
	end

endmodule

//--- verilog/processor.sv
module processor(
	input logic clk,
	input logic rst,
	memBusIf.master mem
);
	import cpuPkg::*;

	decodeIf ctl();

	stateT state;
	instrT instr;
	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] busAddr;
	logic [dataWidth-1:0] nextPc;
	logic [dataWidth-1:0] memAddr;
	logic [dataWidth-1:0] dataOut;
	logic [dataWidth-1:0] wrData;
	logic [dataWidth-1:0] dstData;
	logic [dataWidth-1:0] srcData;
	logic [dataWidth-1:0] aluResult;
	logic memWeReg;
	logic inExec;
	logic aluUpdate;
	logic cFlag;
	logic zFlag;

	assign inExec = (state == EXEC);
	assign aluUpdate = inExec &&
		(ctl.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR});

	regFile regs(.clk(clk), .rst(rst), .we(inExec && ctl.regFileWe), .regDst(ctl.regDst),
		.regSrc(ctl.regSrc), .wrData(wrData), .dstData(dstData), .srcData(srcData));

	alu aluUnit(.clk(clk), .rst(rst), .update(aluUpdate), .op(ctl.opcode), .in1(dstData),
		.in2(srcData), .result(aluResult), .cFlag(cFlag), .zFlag(zFlag));

	decoder dec(.instr(instr), .cFlag(cFlag), .zFlag(zFlag), .ctl(ctl));

	always_comb begin
		case (ctl.nextPcSel)
			PC_ABS: nextPc = ctl.instrData;
			PC_REG: nextPc = srcData;
			default: nextPc = pc + 1'b1;
		endcase
	end

	assign memAddr = ctl.addrSelDst ? dstData : (ctl.addrSelSrc ? srcData : ctl.instrData);
	assign wrData = ctl.immMode ? ctl.instrData : (ctl.indMode ? mem.rdata : aluResult);

	// LD reads its operand during EXEC
	assign mem.addr = (inExec && ctl.indMode) ? memAddr : busAddr;
	assign mem.we = memWeReg;
	assign mem.wdata = dataOut;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= FETCH;
			pc <= '0;
			busAddr <= '0;
			memWeReg <= 1'b0;
		end else begin
			case (state)
				FETCH: state <= EXEC;
				EXEC: begin
					pc <= nextPc;
					if (ctl.memWe) begin
						busAddr <= memAddr;
						memWeReg <= 1'b1;
						state <= WBACK;
					end else begin
						busAddr <= nextPc;
						state <= FETCH;
					end
				end
				default: begin
					busAddr <= pc;
					memWeReg <= 1'b0;
					state <= FETCH;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == FETCH)
			instr <= mem.rdata;
		if (inExec && ctl.memWe)
			dataOut <= srcData;
	end

	stateLegal: assert property (@(posedge clk) disable iff (rst)
		state inside {FETCH, EXEC, WBACK});
	weInWback: assert property (@(posedge clk) disable iff (rst)
		mem.we |-> state == WBACK && $past(state) == EXEC);

endmodule

//--- verilog/programMemory.sv
module programMemory(
	input logic clk,
	memBusIf.slave core,
	input logic loadEn,
	input logic [cpuPkg::memIdxWidth-1:0] loadAddr,
	input logic [cpuPkg::dataWidth-1:0] loadData
);
	import cpuPkg::*;

	logic [dataWidth-1:0] mem [memDepth];
	logic [memIdxWidth-1:0] coreIdx;

	// Upper address bits are ignored
	assign coreIdx = core.addr[memIdxWidth-1:0];

	always_ff @(posedge clk) begin
		if (loadEn)
			mem[loadAddr] <= loadData;
		else if (core.we)
			mem[coreIdx] <= core.wdata;
	end

	assign core.rdata = mem[coreIdx];

	loadExclusive: assert property (@(posedge clk) !(loadEn && core.we));

endmodule

//--- verilog/processorTop.sv
module processorTop(
	input logic clk,
	input logic rst,
	input logic loadEn,
	input logic [cpuPkg::memIdxWidth-1:0] loadAddr,
	input logic [cpuPkg::dataWidth-1:0] loadData,
	output logic memWe,
	output logic [cpuPkg::dataWidth-1:0] addrBus,
	output logic [cpuPkg::dataWidth-1:0] storeData
);

	memBusIf bus();

	processor cpu(
		.clk(clk),
		.rst(rst),
		.mem(bus.master)
	);

	programMemory store(
		.clk(clk),
		.core(bus.slave),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData)
	);

	assign memWe = bus.we;
	assign addrBus = bus.addr;
	assign storeData = bus.wdata;

endmodule

//--- tb/tbTop.sv
module tbTop;
	import cpuPkg::*;

	logic clk;
	logic rst;
	logic loadEn;
	logic [7:0] loadAddr;
	logic [15:0] loadData;
	logic memWe;
	logic [15:0] addrBus;
	logic [15:0] storeData;

	logic [31:0] lfsr;
	logic [15:0] prog[$];
	logic [15:0] expAddr[$];
	logic [15:0] expData[$];
	// Reference model state
	logic [15:0] rm [16];
	logic [15:0] mm [256];
	logic cm;
	logic zm;
	int firstWait;

	processorTop UUT(.clk(clk), .rst(rst), .loadEn(loadEn), .loadAddr(loadAddr),
		.loadData(loadData), .memWe(memWe), .addrBus(addrBus), .storeData(storeData));

	always #20 clk = ~clk;

	task automatic reportFail(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1);
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[14:0], fb};
		end
		return v;
	endfunction

	function automatic logic [15:0] encReg(input opcodeT op, input logic [3:0] d,
		input logic [3:0] s);
		return {op, d, s, 4'h0};
	endfunction

	function automatic logic [15:0] encImm(input opcodeT op, input logic [3:0] d,
		input logic [7:0] imm);
		return {op, d, imm};
	endfunction

	task automatic haltHere();
		prog.push_back(encImm(OP_JMP, 4'd0, 8'(prog.size())));
	endtask

	task automatic modelStore(input logic [15:0] addr, input logic [15:0] data);
		mm[addr[7:0]] = data;
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	// Executes the program from the ISA rules until it jumps to itself
	task automatic runModel();
		logic [15:0] pc;
		logic [15:0] w;
		logic [15:0] nextPc;
		logic [15:0] res;
		logic [3:0] d;
		logic [3:0] s;
		logic cNew;
		logic done;
		int steps;
		pc = '0;
		cm = 1'b0;
		zm = 1'b0;
		done = 1'b0;
		steps = 0;
		expAddr.delete();
		expData.delete();
		for (int i = 0; i < 16; i++) begin
			rm[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			mm[i] = (i < prog.size()) ? prog[i] : '0;
		end
		while (!done && steps < 1000) begin
			w = mm[pc[7:0]];
			d = w[11:8];
			s = w[7:4];
			nextPc = pc + 16'd1;
			cNew = 1'b0;
			res = '0;
			case (opcodeT'(w[15:12]))
				OP_ADD: {cNew, res} = {1'b0, rm[d]} + {1'b0, rm[s]};
				OP_SUB: begin
					res = rm[d] - rm[s];
					cNew = rm[d] < rm[s];
				end
				OP_AND: res = rm[d] & rm[s];
				OP_OR: res = rm[d] | rm[s];
				OP_XOR: res = rm[d] ^ rm[s];
				OP_SHL: {cNew, res} = {rm[d], 1'b0};
				OP_SHR: {res, cNew} = {1'b0, rm[d]};
				OP_MOV: rm[d] = rm[s];
				OP_LDI: rm[d] = {8'h00, w[7:0]};
				OP_LD: rm[d] = mm[rm[s][7:0]];
				OP_ST: modelStore(rm[d], rm[s]);
				OP_STA: modelStore({8'h00, w[7:0]}, rm[d]);
				OP_JMP: nextPc = {8'h00, w[7:0]};
				OP_JZ: nextPc = zm ? {8'h00, w[7:0]} : nextPc;
				OP_JC: nextPc = cm ? {8'h00, w[7:0]} : nextPc;
				default: nextPc = rm[s];
			endcase
			if (w[15:12] < 4'h7) begin
				rm[d] = res;
				cm = cNew;
				zm = (res == 16'h0000);
			end
			done = (nextPc == pc);
			pc = nextPc;
			steps++;
		end
	endtask

	task automatic checkIdle();
		assert (memWe === 1'b0)
		else reportFail($sformatf("ERR memWe got 0x%h expected 0x0", memWe));
		assert (addrBus === 16'h0000)
		else reportFail($sformatf("ERR addrBus got 0x%h expected 0x0000", addrBus));
	endtask

	task automatic expectStore(input logic [15:0] addr, input logic [15:0] data);
		int cycles;
		cycles = 1;
		@(negedge clk);
		while (memWe !== 1'b1) begin
			if (cycles > 200)
				reportFail($sformatf("Timed out waiting for a store to address 0x%h", addr));
			cycles++;
			@(negedge clk);
		end
		firstWait = cycles;
		assert (addrBus === addr)
		else reportFail($sformatf("ERR addrBus got 0x%h expected 0x%h", addrBus, addr));
		assert (storeData === data)
		else reportFail($sformatf("ERR storeData got 0x%h expected 0x%h", storeData, data));
	endtask

	// Load while held in reset, then check every predicted store in order
	task automatic runProgram();
		int waits[$];
		runModel();
		@(negedge clk);
		rst = 1'b1;
		for (int i = 0; i < prog.size(); i++) begin
			@(negedge clk);
			loadEn = 1'b1;
			loadAddr = 8'(i);
			loadData = prog[i];
			checkIdle();
		end
		@(negedge clk);
		loadEn = 1'b0;
		@(negedge clk);
		checkIdle();
		rst = 1'b0;
		foreach (expAddr[k]) begin
			expectStore(expAddr[k], expData[k]);
			waits.push_back(firstWait);
		end
		firstWait = waits[0];
	endtask

	task automatic resetBehavior();
		logic [15:0] r;
		r = randBits(8);
		prog.delete();
		prog.push_back(encImm(OP_LDI, 4'd1, r[7:0]));
		prog.push_back(encImm(OP_STA, 4'd1, 8'h80));
		haltHere();
		runProgram();
		// Two cycles of LDI, then the third cycle of STA
		assert (firstWait == 4)
		else reportFail($sformatf("First store came after %0d cycles instead of 4", firstWait));
	endtask

	task automatic aluOps();
		logic [15:0] a;
		logic [15:0] b;
		prog.delete();
		for (int i = 0; i < 8; i++) begin
			a = randBits(8);
			b = randBits(8);
			prog.push_back(encImm(OP_LDI, 4'd1, a[7:0]));
			prog.push_back(encImm(OP_LDI, 4'd2, b[7:0]));
			prog.push_back(encReg(opcodeT'(4'(i)), 4'd1, 4'd2));
			prog.push_back(encImm(OP_STA, 4'd1, 8'h90 + 8'(i)));
		end
		haltHere();
		runProgram();
	endtask

	// C is cleared by AND before the overflowing ADD
	task automatic flagJumps();
		prog = '{encImm(OP_LDI, 4'd1, 8'h5A), encImm(OP_LDI, 4'd2, 8'h5A),
			encReg(OP_SUB, 4'd1, 4'd2), encImm(OP_JZ, 4'd0, 8'd6),
			encImm(OP_LDI, 4'd3, 8'hBD), encImm(OP_STA, 4'd3, 8'hA0),
			encImm(OP_LDI, 4'd3, 8'h11), encImm(OP_STA, 4'd3, 8'hA0),
			encImm(OP_LDI, 4'd2, 8'h33), encReg(OP_SUB, 4'd1, 4'd2),
			encImm(OP_JZ, 4'd0, 8'd13), encImm(OP_LDI, 4'd3, 8'h22),
			encImm(OP_STA, 4'd3, 8'hA1), encReg(OP_AND, 4'd2, 4'd2),
			encReg(OP_ADD, 4'd1, 4'd1), encImm(OP_JC, 4'd0, 8'd18),
			encImm(OP_LDI, 4'd3, 8'hBE), encImm(OP_STA, 4'd3, 8'hA2),
			encImm(OP_LDI, 4'd3, 8'h33), encImm(OP_STA, 4'd3, 8'hA2),
			encReg(OP_AND, 4'd1, 4'd2), encImm(OP_JC, 4'd0, 8'd24),
			encImm(OP_LDI, 4'd3, 8'h44), encImm(OP_STA, 4'd3, 8'hA3)};
		haltHere();
		runProgram();
	endtask

	task automatic memModes();
		logic [15:0] v;
		v = randBits(8);
		prog = '{encImm(OP_LDI, 4'd1, 8'hC0), encImm(OP_LDI, 4'd2, v[7:0]),
			encReg(OP_SHL, 4'd2, 4'd0), encReg(OP_ST, 4'd1, 4'd2),
			encReg(OP_LD, 4'd3, 4'd1), encImm(OP_STA, 4'd3, 8'hC8)};
		haltHere();
		runProgram();
	endtask

	task automatic registerJump();
		prog = '{encImm(OP_LDI, 4'd1, 8'h08), encReg(OP_JR, 4'd0, 4'd1),
			encImm(OP_LDI, 4'd3, 8'hEE), encImm(OP_STA, 4'd3, 8'hB0),
			encImm(OP_LDI, 4'd15, 8'h00), encImm(OP_LDI, 4'd15, 8'h00),
			encImm(OP_LDI, 4'd15, 8'h00), encImm(OP_LDI, 4'd15, 8'h00),
			encImm(OP_LDI, 4'd3, 8'h55), encImm(OP_STA, 4'd3, 8'hB0),
			encImm(OP_JMP, 4'd0, 8'd14), encImm(OP_LDI, 4'd3, 8'hEF),
			encImm(OP_STA, 4'd3, 8'hB1), encImm(OP_JMP, 4'd0, 8'd13),
			encImm(OP_LDI, 4'd3, 8'h66), encImm(OP_STA, 4'd3, 8'hB1)};
		haltHere();
		runProgram();
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		loadEn = 1'b0;
		loadAddr = 8'h00;
		loadData = 16'h0000;
		lfsr = 32'h16a1_4765;
		repeat (8) @(negedge clk);
		checkIdle();
		resetBehavior();
		aluOps();
		flagJumps();
		memModes();
		registerJump();
		$display("Regression passed");
		$finish;
	end

endmodule

//--- src.f
verilog/cpuPkg.sv
verilog/memBusIf.sv
verilog/decodeIf.sv
verilog/regFile.sv
verilog/alu.sv
verilog/decoder.sv
verilog/processor.sv
verilog/programMemory.sv
verilog/processorTop.sv
tb/tbTop.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = tbTop
FILELIST = src.f
BUILD = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
